// File: run_sim.sh
#!/usr/bin/env bash
# build the counter testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
log_file=sim.log

if ! verilator --binary --assert -j 0 --top-module tb_cl_counter \
    -Mdir obj_dir -o sim_cl_counter -f vlog.f; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_cl_counter > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ "$run_status" -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "TESTS FAILED" "$log_file"; then
  exit 1
fi
if ! grep -q "TESTS PASSED" "$log_file"; then
  echo "no pass line found in $log_file"
  exit 1
fi
exit 0

// File: source/cl_counter_pkg.sv
/* register map, widths, id constants and packed structs shared by
   the ocl register slave, the tick prescaler and the event counter */

package cl_counter_pkg;

  // --------------------
  // widths
  localparam int OCL_ADDR_W = 8;                      // register window is 256 bytes
  localparam int OCL_DATA_W = 32;                     // axi-lite data bus
  localparam int OCL_STRB_W = OCL_DATA_W / 8;         // one strobe per byte lane
  localparam int TICK_W     = 8;                      // prescaler width
  localparam int CNT_W      = 16;                     // event counter width

  // --------------------
  // read-only id and status words
  localparam logic [31:0] CL_ID0     = 32'hA5C0_0100;   // vendor / device id pair
  localparam logic [31:0] CL_ID1     = 32'h0001_5A3C;   // subsystem id pair
  localparam logic [31:0] CL_STATUS0 = 32'h0000_0FF0;   // fixed status tie-off
  localparam logic [31:0] CL_VERSION = 32'hEEEE_EE00;   // design version tie-off

  // --------------------
  // register offsets
  localparam logic [OCL_ADDR_W-1:0] REG_ID0      = 8'h00;  // ro
  localparam logic [OCL_ADDR_W-1:0] REG_ID1      = 8'h04;  // ro
  localparam logic [OCL_ADDR_W-1:0] REG_STATUS   = 8'h08;  // ro
  localparam logic [OCL_ADDR_W-1:0] REG_VERSION  = 8'h0C;  // ro
  localparam logic [OCL_ADDR_W-1:0] REG_CTRL     = 8'h10;  // enable, load, clear, one-shot
  localparam logic [OCL_ADDR_W-1:0] REG_TICK     = 8'h14;  // prescale terminal value
  localparam logic [OCL_ADDR_W-1:0] REG_LOAD     = 8'h18;  // counter load value
  localparam logic [OCL_ADDR_W-1:0] REG_WMARK    = 8'h1C;  // watermark
  localparam logic [OCL_ADDR_W-1:0] REG_COUNT    = 8'h20;  // ro, flag in bit 16
  localparam logic [OCL_ADDR_W-1:0] REG_TICK_CNT = 8'h24;  // ro, live prescaler

  // response codes
  localparam logic [1:0] RESP_OKAY   = 2'd0;
  localparam logic [1:0] RESP_SLVERR = 2'd2;

  // --------------------
  // master side of the ocl port
  typedef struct packed {
    logic                  awvalid;
    logic [OCL_ADDR_W-1:0] awaddr;
    logic                  wvalid;
    logic [OCL_DATA_W-1:0] wdata;
    logic [OCL_STRB_W-1:0] wstrb;
    logic                  bready;
    logic                  arvalid;
    logic [OCL_ADDR_W-1:0] araddr;
    logic                  rready;
  } ocl_req_t;

  // slave side of the ocl port
  typedef struct packed {
    logic                  awready;
    logic                  wready;
    logic                  bvalid;
    logic [1:0]            bresp;
    logic                  arready;
    logic                  rvalid;
    logic [OCL_DATA_W-1:0] rdata;
    logic [1:0]            rresp;
  } ocl_rsp_t;

  // control shadow seen by prescaler and counter
  typedef struct packed {
    logic              enable;      // level
    logic              oneshot;     // level, saturate at max
    logic              load;        // one-cycle pulse
    logic              clear;       // one-cycle pulse
    logic [TICK_W-1:0] tick_value;
    logic [CNT_W-1:0]  load_value;
    logic [CNT_W-1:0]  watermark;
  } cnt_cfg_t;

  // counter status back to the slave
  typedef struct packed {
    logic [CNT_W-1:0] cnt;
    logic             ge_watermark;
  } cnt_stat_t;

endpackage

// File: source/cl_counter_top.sv
/* top level: ocl register slave driving the tick prescaler and event counter */
`timescale 1ns/1ns

module cl_counter_top (
  input  logic                     clk_main_a0,
  input  logic                     rst_main_n,
  input  cl_counter_pkg::ocl_req_t ocl_req,
  output cl_counter_pkg::ocl_rsp_t ocl_rsp
);

  import cl_counter_pkg::*;

  // --------------------
  // internal links
  cnt_cfg_t          cnt_cfg;      // control shadow from the slave
  cnt_stat_t         cnt_stat;     // count and watermark flag
  logic              tick;         // prescaler to counter
  logic [TICK_W-1:0] tick_cnt;     // live prescale count for readback

  ocl_reg_slave ocl_reg_slave_inst (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .ocl_req     (ocl_req),
    .ocl_rsp     (ocl_rsp),
    .cnt_stat    (cnt_stat),
    .tick_cnt    (tick_cnt),
    .cnt_cfg     (cnt_cfg)
  );

  tick_prescaler tick_prescaler_inst (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .cnt_cfg     (cnt_cfg),
    .tick        (tick),
    .tick_cnt    (tick_cnt)
  );

  event_counter event_counter_inst (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .cnt_cfg     (cnt_cfg),
    .tick        (tick),
    .cnt_stat    (cnt_stat)
  );

endmodule

// File: source/event_counter.sv
/* 16-bit event counter with clear, load, one-shot saturation
   and a registered watermark compare */
`timescale 1ns/1ns

module event_counter (
  input  logic                      clk_main_a0,
  input  logic                      rst_main_n,
  input  cl_counter_pkg::cnt_cfg_t  cnt_cfg,
  input  logic                      tick,
  output cl_counter_pkg::cnt_stat_t cnt_stat
);

  import cl_counter_pkg::*;

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_next;
  logic             ge_q;          // count at or above watermark
  logic             at_max;

  assign at_max = (cnt_q == {CNT_W{1'b1}});

  // --------------------
  // next count, clear > load > enabled tick
  always_comb
  begin
    cnt_next = cnt_q;
    if (cnt_cfg.clear)
      cnt_next = '0;
    else if (cnt_cfg.load)
      cnt_next = cnt_cfg.load_value;
    else if (cnt_cfg.enable && tick)
    begin
      if (!(cnt_cfg.oneshot && at_max))
        cnt_next = cnt_q + CNT_W'(1);          // wraps when one-shot is off
    end
  end

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
    begin
      cnt_q <= '0;
      ge_q  <= 1'b0;
    end
    else
    begin
      cnt_q <= cnt_next;
      ge_q  <= (cnt_next >= cnt_cfg.watermark);  // aligned with the new count
    end
  end

  assign cnt_stat.cnt          = cnt_q;
  assign cnt_stat.ge_watermark = ge_q;

endmodule

// File: source/ocl_reg_slave.sv
/* axi-lite register slave on the ocl port: id and status registers,
   counter control shadow with load/clear pulses, live counter readback */
`timescale 1ns/1ns

module ocl_reg_slave (
  input  logic                              clk_main_a0,
  input  logic                              rst_main_n,
  input  cl_counter_pkg::ocl_req_t          ocl_req,
  output cl_counter_pkg::ocl_rsp_t          ocl_rsp,
  input  cl_counter_pkg::cnt_stat_t         cnt_stat,
  input  logic [cl_counter_pkg::TICK_W-1:0] tick_cnt,
  output cl_counter_pkg::cnt_cfg_t          cnt_cfg
);

  import cl_counter_pkg::*;

  // byte-lane merge for the 16-bit fields
  function automatic logic [CNT_W-1:0] strb_merge(
    input logic [CNT_W-1:0]      old_val,
    input logic [OCL_DATA_W-1:0] data,
    input logic [OCL_STRB_W-1:0] strb
  );
    logic [CNT_W-1:0] res;
    res = old_val;
    for (int b = 0; b < CNT_W / 8; b++)
    begin
      if (strb[b])
        res[8*b +: 8] = data[8*b +: 8];  // only enabled lanes
    end
    return res;
  endfunction

  // --------------------
  // write channel
  logic                  aw_w_ready_q;  // shared awready / wready
  logic                  bvalid_q;
  logic [1:0]            bresp_q;
  logic                  wr_hs;         // write performed at this edge
  logic                  wr_ok;         // offset is writable
  logic [OCL_ADDR_W-1:0] wr_addr;
  cnt_cfg_t              cfg_q;         // registered control shadow

  assign wr_addr = ocl_req.awaddr;
  assign wr_hs   = aw_w_ready_q & ocl_req.awvalid & ocl_req.wvalid;

  always_comb
  begin
    case (wr_addr)
      REG_CTRL, REG_TICK, REG_LOAD, REG_WMARK: wr_ok = 1'b1;
      default:                                 wr_ok = 1'b0;  // ro or unmapped
    endcase
  end

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
    begin
      aw_w_ready_q <= 1'b0;
      bvalid_q     <= 1'b0;
    end
    else
    begin
      // one-cycle ready, only with no response pending
      aw_w_ready_q <= ocl_req.awvalid & ocl_req.wvalid & ~aw_w_ready_q & ~bvalid_q;
      if (wr_hs)
        bvalid_q <= 1'b1;                      // response next cycle
      else if (ocl_req.bready)
        bvalid_q <= 1'b0;                      // held until accepted
    end
  end

  always_ff @(posedge clk_main_a0)
  begin
    if (wr_hs)
      bresp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
  end

  // --------------------
  // control shadow
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
      cfg_q <= '0;
    else
    begin
      cfg_q.load  <= 1'b0;                     // pulses self-clear
      cfg_q.clear <= 1'b0;
      if (wr_hs)
      begin
        case (wr_addr)
          REG_CTRL:
          begin
            if (ocl_req.wstrb[0])
            begin
              cfg_q.enable  <= ocl_req.wdata[0];
              cfg_q.load    <= ocl_req.wdata[1];
              cfg_q.clear   <= ocl_req.wdata[2];
              cfg_q.oneshot <= ocl_req.wdata[3];
            end
          end
          REG_TICK:
          begin
            if (ocl_req.wstrb[0])
              cfg_q.tick_value <= ocl_req.wdata[TICK_W-1:0];
          end
          REG_LOAD:  cfg_q.load_value <= strb_merge(cfg_q.load_value, ocl_req.wdata,
                                                     ocl_req.wstrb);
          REG_WMARK: cfg_q.watermark  <= strb_merge(cfg_q.watermark, ocl_req.wdata,
                                                     ocl_req.wstrb);
          default:   ;                         // slverr, nothing changes
        endcase
      end
    end
  end

  assign cnt_cfg = cfg_q;

  // --------------------
  // read channel
  logic                  arready_q;
  logic                  rvalid_q;
  logic [OCL_DATA_W-1:0] rdata_q;
  logic [1:0]            rresp_q;
  logic                  rd_hs;
  logic [OCL_DATA_W-1:0] rd_data;              // mux output
  logic [1:0]            rd_resp;

  assign rd_hs = arready_q & ocl_req.arvalid;

  always_comb
  begin
    rd_resp = RESP_OKAY;
    case (ocl_req.araddr)
      REG_ID0:      rd_data = CL_ID0;
      REG_ID1:      rd_data = CL_ID1;
      REG_STATUS:   rd_data = CL_STATUS0;
      REG_VERSION:  rd_data = CL_VERSION;
      REG_CTRL:     rd_data = {28'd0, cfg_q.oneshot, cfg_q.clear, cfg_q.load, cfg_q.enable};
      REG_TICK:     rd_data = {{(OCL_DATA_W-TICK_W){1'b0}}, cfg_q.tick_value};
      REG_LOAD:     rd_data = {{(OCL_DATA_W-CNT_W){1'b0}}, cfg_q.load_value};
      REG_WMARK:    rd_data = {{(OCL_DATA_W-CNT_W){1'b0}}, cfg_q.watermark};
      REG_COUNT:    rd_data = {{(OCL_DATA_W-CNT_W-1){1'b0}}, cnt_stat.ge_watermark,
                               cnt_stat.cnt};
      REG_TICK_CNT: rd_data = {{(OCL_DATA_W-TICK_W){1'b0}}, tick_cnt};
      default:
      begin
        rd_data = '0;                          // unmapped reads zero
        rd_resp = RESP_SLVERR;
      end
    endcase
  end

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
    begin
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
    end
    else
    begin
      arready_q <= ocl_req.arvalid & ~arready_q & ~rvalid_q;
      if (rd_hs)
        rvalid_q <= 1'b1;
      else if (ocl_req.rready)
        rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_main_a0)
  begin
    if (rd_hs)
    begin
      rdata_q <= rd_data;                      // sampled at the handshake edge
      rresp_q <= rd_resp;
    end
  end

  always_comb
  begin
    ocl_rsp.awready = aw_w_ready_q;
    ocl_rsp.wready  = aw_w_ready_q;
    ocl_rsp.bvalid  = bvalid_q;
    ocl_rsp.bresp   = bresp_q;
    ocl_rsp.arready = arready_q;
    ocl_rsp.rvalid  = rvalid_q;
    ocl_rsp.rdata   = rdata_q;
    ocl_rsp.rresp   = rresp_q;
  end

endmodule

// File: source/tick_prescaler.sv
/* prescale counter that emits one tick every tick_value+1 enabled cycles */
`timescale 1ns/1ns

module tick_prescaler (
  input  logic                              clk_main_a0,
  input  logic                              rst_main_n,
  input  cl_counter_pkg::cnt_cfg_t          cnt_cfg,
  output logic                              tick,
  output logic [cl_counter_pkg::TICK_W-1:0] tick_cnt
);

  import cl_counter_pkg::*;

  logic [TICK_W-1:0] tick_cnt_q;
  logic              at_term;      // reached the terminal value

  assign at_term = (tick_cnt_q >= cnt_cfg.tick_value);

  // --------------------
  // prescale count
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
      tick_cnt_q <= '0;
    else if (cnt_cfg.clear)
      tick_cnt_q <= '0;                        // clear wins
    else if (cnt_cfg.enable)
    begin
      if (at_term)
        tick_cnt_q <= '0;                      // wrap after terminal value
      else
        tick_cnt_q <= tick_cnt_q + TICK_W'(1);
    end
  end

  assign tick     = at_term;                   // counter qualifies with enable
  assign tick_cnt = tick_cnt_q;

endmodule

// File: tb/tb_cl_counter.sv
/* testbench for cl_counter_top: clock, reset, axi-lite read/write tasks,
   stimulus table with expected values applied in a loop, per-test report */
`timescale 1ns/1ns

module tb_cl_counter;

  import cl_counter_pkg::*;

  // --------------------
  // table encoding
  localparam logic [2:0] OP_WR   = 3'd0;   // write, check bresp
  localparam logic [2:0] OP_RD   = 3'd1;   // read, masked compare
  localparam logic [2:0] OP_WAIT = 3'd2;   // idle for data cycles
  localparam logic [2:0] OP_POLL = 3'd3;   // read until masked value matches
  localparam logic [2:0] OP_LE   = 3'd4;   // masked value at most exp
  localparam logic [2:0] OP_NZ   = 3'd5;   // masked value non-zero, kept
  localparam logic [2:0] OP_SAME = 3'd6;   // masked value equals the kept one
  localparam int HS_TIMEOUT = 50;          // cycles per handshake wait
  localparam int POLL_LIMIT = 100;         // reads per poll row
  localparam int WATCHDOG   = 20000;

  typedef struct packed {
    logic [2:0]  op;
    logic [7:0]  offset;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [31:0] exp;      // already within mask
    logic [31:0] mask;
    logic [1:0]  resp;
  } stim_row_t;

  logic      clk_main_a0;
  logic      rst_main_n;
  ocl_req_t  ocl_req;
  ocl_rsp_t  ocl_rsp;
  stim_row_t stim_q[$];
  integer    seed = 32'h22288703;
  int        err_cnt = 0;

  cl_counter_top cl_counter_top_inst (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .ocl_req     (ocl_req),
    .ocl_rsp     (ocl_rsp)
  );

  always #5 clk_main_a0 = ~clk_main_a0;   // 10 ns period

  // --------------------
  // helpers
  task automatic step_cycle();
    @(posedge clk_main_a0);
    #1;                                    // drive and sample after the edge
  endtask

  task automatic report_mismatch(input int idx, input string what,
                                 input logic [31:0] got, input logic [31:0] want);
    $display("Mismatch at %0t ns: test %0d %s read 0x%08h, expected 0x%08h",
             $time, idx, what, got, want);
    err_cnt++;
  endtask

  task automatic ocl_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] resp);
    int wait_cnt;
    ocl_req.awvalid = 1'b1;
    ocl_req.awaddr  = addr;
    ocl_req.wvalid  = 1'b1;
    ocl_req.wdata   = data;
    ocl_req.wstrb   = strb;
    wait_cnt = 0;
    while (!ocl_rsp.awready && !ocl_rsp.wready && wait_cnt < HS_TIMEOUT)
    begin
      step_cycle();
      wait_cnt++;
    end
    if (!ocl_rsp.awready && !ocl_rsp.wready)
    begin
      $display("Timeout: write to offset 0x%02h was never accepted", addr);
      err_cnt++;
    end
    else if (ocl_rsp.awready !== ocl_rsp.wready)
    begin
      $display("Error: awready and wready not raised together for offset 0x%02h", addr);
      err_cnt++;
    end
    step_cycle();                          // handshake edge
    ocl_req.awvalid = 1'b0;
    ocl_req.wvalid  = 1'b0;
    ocl_req.bready  = 1'b1;
    wait_cnt = 0;
    while (!ocl_rsp.bvalid && wait_cnt < HS_TIMEOUT)
    begin
      step_cycle();
      wait_cnt++;
    end
    if (!ocl_rsp.bvalid)
    begin
      $display("Timeout: no write response for offset 0x%02h", addr);
      err_cnt++;
    end
    resp = ocl_rsp.bresp;
    step_cycle();                          // response taken here
    ocl_req.bready = 1'b0;
  endtask

  task automatic ocl_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int wait_cnt;
    ocl_req.arvalid = 1'b1;
    ocl_req.araddr  = addr;
    wait_cnt = 0;
    while (!ocl_rsp.arready && wait_cnt < HS_TIMEOUT)
    begin
      step_cycle();
      wait_cnt++;
    end
    if (!ocl_rsp.arready)
    begin
      $display("Timeout: read of offset 0x%02h was never accepted", addr);
      err_cnt++;
    end
    step_cycle();
    ocl_req.arvalid = 1'b0;
    ocl_req.rready  = 1'b1;
    wait_cnt = 0;
    while (!ocl_rsp.rvalid && wait_cnt < HS_TIMEOUT)
    begin
      step_cycle();
      wait_cnt++;
    end
    if (!ocl_rsp.rvalid)
    begin
      $display("Timeout: no read data for offset 0x%02h", addr);
      err_cnt++;
    end
    data = ocl_rsp.rdata;
    resp = ocl_rsp.rresp;
    step_cycle();
    ocl_req.rready = 1'b0;
  endtask

  task automatic add_write(input logic [7:0] off, input logic [31:0] data,
                           input logic [3:0] strb, input logic [1:0] resp);
    stim_q.push_back('{OP_WR, off, data, strb, 32'd0, 32'd0, resp});
  endtask

  task automatic add_check(input logic [2:0] op, input logic [7:0] off,
                           input logic [31:0] exp, input logic [31:0] mask,
                           input logic [1:0] resp);
    stim_q.push_back('{op, off, 32'd0, 4'h0, exp, mask, resp});
  endtask

  task automatic add_wait(input logic [31:0] cycles);
    stim_q.push_back('{OP_WAIT, 8'h00, cycles, 4'h0, 32'd0, 32'd0, RESP_OKAY});
  endtask

  // --------------------
  // stimulus table
  task automatic build_table();
    logic [31:0] rnd_a;
    logic [31:0] rnd_b;
    rnd_a = $random(seed);
    rnd_b = $random(seed);
    // id, status and version, writes rejected
    add_check(OP_RD, REG_ID0, CL_ID0, 32'hFFFF_FFFF, RESP_OKAY);
    add_check(OP_RD, REG_ID1, CL_ID1, 32'hFFFF_FFFF, RESP_OKAY);
    add_check(OP_RD, REG_STATUS, CL_STATUS0, 32'hFFFF_FFFF, RESP_OKAY);
    add_check(OP_RD, REG_VERSION, CL_VERSION, 32'hFFFF_FFFF, RESP_OKAY);
    add_write(REG_ID0, 32'hDEAD_BEEF, 4'hF, RESP_SLVERR);
    add_write(REG_VERSION, 32'h1234_5678, 4'hF, RESP_SLVERR);
    add_write(REG_COUNT, 32'h0000_ABCD, 4'hF, RESP_SLVERR);
    add_write(8'h40, 32'h5555_AAAA, 4'hF, RESP_SLVERR);   // unmapped
    add_check(OP_RD, REG_ID0, CL_ID0, 32'hFFFF_FFFF, RESP_OKAY);
    add_check(OP_RD, REG_VERSION, CL_VERSION, 32'hFFFF_FFFF, RESP_OKAY);
    add_check(OP_RD, REG_COUNT, 32'd0, 32'h0000_FFFF, RESP_OKAY);
    add_check(OP_RD, 8'h40, 32'd0, 32'hFFFF_FFFF, RESP_SLVERR);
    // config registers, full and byte-lane writes
    add_write(REG_TICK, rnd_a, 4'hF, RESP_OKAY);
    add_write(REG_TICK, 32'h0000_00A5, 4'h0, RESP_OKAY);  // no lanes, no change
    add_check(OP_RD, REG_TICK, {24'd0, rnd_a[7:0]}, 32'hFFFF_FFFF, RESP_OKAY);
    add_write(REG_LOAD, 32'h0000_1234, 4'hF, RESP_OKAY);
    add_write(REG_LOAD, 32'hFFFF_CD00, 4'h2, RESP_OKAY);  // upper byte only
    add_check(OP_RD, REG_LOAD, 32'h0000_CD34, 32'hFFFF_FFFF, RESP_OKAY);
    add_write(REG_WMARK, rnd_a, 4'hF, RESP_OKAY);
    add_write(REG_WMARK, 32'h0000_00EF, 4'h1, RESP_OKAY);  // lower byte only
    add_check(OP_RD, REG_WMARK, {16'd0, rnd_a[15:8], 8'hEF}, 32'hFFFF_FFFF, RESP_OKAY);
    // load with enable off, then clear
    add_write(REG_LOAD, rnd_b, 4'hF, RESP_OKAY);
    add_write(REG_CTRL, 32'h2, 4'h1, RESP_OKAY);
    add_check(OP_RD, REG_COUNT, {16'd0, rnd_b[15:0]}, 32'h0000_FFFF, RESP_OKAY);
    add_check(OP_RD, REG_COUNT, {16'd0, rnd_b[15:0]}, 32'h0000_FFFF, RESP_OKAY);
    add_write(REG_TICK, 32'h0000_00FF, 4'hF, RESP_OKAY);  // no tick for 255 cycles
    add_write(REG_CTRL, 32'h1, 4'h1, RESP_OKAY);          // prescaler moves off zero
    add_check(OP_NZ, REG_TICK_CNT, 32'd0, 32'hFFFF_FFFF, RESP_OKAY);
    add_write(REG_CTRL, 32'h4, 4'h1, RESP_OKAY);          // clear, enable off
    add_check(OP_RD, REG_COUNT, 32'd0, 32'h0000_FFFF, RESP_OKAY);
    add_check(OP_RD, REG_TICK_CNT, 32'd0, 32'hFFFF_FFFF, RESP_OKAY);
    // prescaled counting, then hold
    add_write(REG_TICK, 32'd3, 4'hF, RESP_OKAY);
    add_write(REG_CTRL, 32'h1, 4'h1, RESP_OKAY);
    add_wait(32'd40);
    add_write(REG_CTRL, 32'h0, 4'h1, RESP_OKAY);
    add_check(OP_LE, REG_TICK_CNT, 32'd3, 32'hFFFF_FFFF, RESP_OKAY);
    add_check(OP_NZ, REG_COUNT, 32'd0, 32'h0000_FFFF, RESP_OKAY);
    add_check(OP_SAME, REG_COUNT, 32'd0, 32'h0000_FFFF, RESP_OKAY);
    // one-shot saturation, then wrap
    add_write(REG_TICK, 32'd0, 4'hF, RESP_OKAY);
    add_write(REG_LOAD, 32'h0000_FFFD, 4'hF, RESP_OKAY);
    add_write(REG_CTRL, 32'h2, 4'h1, RESP_OKAY);
    add_write(REG_CTRL, 32'h9, 4'h1, RESP_OKAY);         // enable and one-shot
    add_check(OP_POLL, REG_COUNT, 32'h0000_FFFF, 32'h0000_FFFF, RESP_OKAY);
    add_wait(32'd8);
    add_check(OP_RD, REG_COUNT, 32'h0000_FFFF, 32'h0000_FFFF, RESP_OKAY);
    add_write(REG_LOAD, 32'h0000_FFFF, 4'hF, RESP_OKAY);
    add_write(REG_CTRL, 32'h2, 4'h1, RESP_OKAY);         // load, disables too
    add_write(REG_CTRL, 32'h1, 4'h1, RESP_OKAY);
    add_check(OP_LE, REG_COUNT, 32'h0000_00FF, 32'h0000_FFFF, RESP_OKAY);
    // watermark flag
    add_write(REG_WMARK, 32'h0000_0010, 4'hF, RESP_OKAY);
    add_write(REG_LOAD, 32'h0000_000F, 4'hF, RESP_OKAY);
    add_write(REG_CTRL, 32'h2, 4'h1, RESP_OKAY);
    add_check(OP_RD, REG_COUNT, 32'h0000_000F, 32'h0001_FFFF, RESP_OKAY);
    add_write(REG_LOAD, 32'h0000_0010, 4'hF, RESP_OKAY);
    add_write(REG_CTRL, 32'h2, 4'h1, RESP_OKAY);
    add_check(OP_RD, REG_COUNT, 32'h0001_0010, 32'h0001_FFFF, RESP_OKAY);
  endtask

  // --------------------
  // main sequence
  initial
  begin
    stim_row_t   row;
    logic [31:0] rdata;
    logic [31:0] masked;
    logic [31:0] kept;
    logic [1:0]  resp;
    int          row_err;
    int          polls;
    int          pass_cnt;
    int          fail_cnt;
    clk_main_a0 = 1'b0;
    rst_main_n  = 1'b0;
    ocl_req     = '0;
    kept        = '0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    build_table();
    for (int c = 0; c < 3; c++)
      step_cycle();                        // reset held for 3 cycles
    rst_main_n = 1'b1;
    step_cycle();
    for (int i = 0; i < stim_q.size(); i++)
    begin
      row     = stim_q[i];
      row_err = err_cnt;
      if (row.op == OP_WR)
      begin
        ocl_write(row.offset, row.data, row.strb, resp);
        if (resp !== row.resp)
          report_mismatch(i, "write response", {30'd0, resp}, {30'd0, row.resp});
      end
      else if (row.op == OP_WAIT)
      begin
        for (int c = 0; c < int'(row.data); c++)
          step_cycle();
      end
      else
      begin
        ocl_read(row.offset, rdata, resp);
        polls = 0;
        while (row.op == OP_POLL && (rdata & row.mask) !== row.exp && polls < POLL_LIMIT)
        begin
          ocl_read(row.offset, rdata, resp);
          polls++;
        end
        masked = rdata & row.mask;
        if (resp !== row.resp)
          report_mismatch(i, "read response", {30'd0, resp}, {30'd0, row.resp});
        if (row.op == OP_POLL && masked !== row.exp)
        begin
          $display("Timeout: offset 0x%02h never reached 0x%08h in %0d polls",
                   row.offset, row.exp, POLL_LIMIT);
          err_cnt++;
        end
        if (row.op == OP_RD && masked !== row.exp)
          report_mismatch(i, "value", masked, row.exp);
        if (row.op == OP_LE && masked > row.exp)
          report_mismatch(i, "value above limit", masked, row.exp);
        if (row.op == OP_NZ && masked == 32'd0)
          report_mismatch(i, "zero value", masked, 32'd1);
        if (row.op == OP_SAME && masked !== kept)
          report_mismatch(i, "changed value", masked, kept);
        kept = masked;
      end
      if (err_cnt == row_err)
        pass_cnt++;
      else
        fail_cnt++;
      $display("test %0d op %0d offset 0x%02h: %s", i, row.op, row.offset,
               (err_cnt == row_err) ? "ok" : "error");
    end
    $display("summary: %0d tests, %0d passed, %0d failed", stim_q.size(), pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  // overall limit on the run
  initial
  begin
    for (int c = 0; c < WATCHDOG; c++)
      @(posedge clk_main_a0);
    $display("Timeout: simulation did not finish within %0d cycles", WATCHDOG);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: tb/tb_cl_counter_assert.sv
/* concurrent checks on the ocl response handshakes and the event count,
   bound into cl_counter_top */
`timescale 1ns/1ns

module cl_counter_assert (
  input logic                      clk_main_a0,
  input logic                      rst_main_n,
  input cl_counter_pkg::ocl_req_t  ocl_req,
  input cl_counter_pkg::ocl_rsp_t  ocl_rsp,
  input cl_counter_pkg::cnt_cfg_t  cnt_cfg,
  input cl_counter_pkg::cnt_stat_t cnt_stat
);

  // --------------------
  // response hold under back-pressure
  bvalid_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
    ocl_rsp.bvalid && !ocl_req.bready |=> ocl_rsp.bvalid)
    else $error("bvalid dropped before bready");

  rvalid_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
    ocl_rsp.rvalid && !ocl_req.rready |=> ocl_rsp.rvalid && $stable(ocl_rsp.rdata))
    else $error("rvalid or rdata changed before rready");

  // --------------------
  // count is frozen with no enable, load or clear
  count_idle: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
    !cnt_cfg.enable && !cnt_cfg.load && !cnt_cfg.clear |=> $stable(cnt_stat.cnt))
    else $error("count changed while idle");

endmodule

bind cl_counter_top cl_counter_assert cl_counter_assert_inst (
  .clk_main_a0 (clk_main_a0),
  .rst_main_n  (rst_main_n),
  .ocl_req     (ocl_req),
  .ocl_rsp     (ocl_rsp),
  .cnt_cfg     (cnt_cfg),
  .cnt_stat    (cnt_stat)
);

// File: vlog.f
source/cl_counter_pkg.sv
source/ocl_reg_slave.sv
source/tick_prescaler.sv
source/event_counter.sv
source/cl_counter_top.sv
tb/tb_cl_counter_assert.sv
tb/tb_cl_counter.sv
